//--- filelist.f
lms_pkg.sv
wb_regs_pkg.sv
lms_rx_deinterleave.sv
lms_tx_interleave.sv
frontend_ctrl_regs.sv
lms_frontend_top.sv
lms_frontend_properties.sv
tb_lms_frontend.sv

//--- tb_lms_frontend.sv
// Self-checking testbench, fixed xorshift seed, inputs change 2 ns after the rising edge
module tb_lms_frontend
   import lms_pkg::*;
   import wb_regs_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RST_CYCLES    = 16;
   localparam int REG_ITERS     = 16;
   localparam int RX_CYCLES     = 500;
   localparam int RX_DIS_CYCLES = 100;
   localparam int TX_CYCLES     = 500;
   localparam int TX_DIS_CYCLES = 100;
   localparam int ACK_LIMIT     = 16;
   localparam int WB_OPS        = 5 + 4 * REG_ITERS + 12;
   localparam int TEST_CYCLES   = RST_CYCLES + 3 * WB_OPS + RX_CYCLES + RX_DIS_CYCLES
                                + TX_CYCLES + TX_DIS_CYCLES + 20;
   localparam int CYCLE_LIMIT   = 2 * TEST_CYCLES + 200;

   logic       dsp_clk;
   logic       arst_n_i;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   lms_bus_t   rx_bus [NUM_CHANNELS];
   iq_pair_t   rx_pair [NUM_CHANNELS];
   logic       rx_valid [NUM_CHANNELS];
   iq_pair_t   tx_pair [NUM_CHANNELS];
   logic       tx_valid [NUM_CHANNELS];
   logic       tx_ready [NUM_CHANNELS];
   lms_bus_t   tx_bus [NUM_CHANNELS];
   chan_mask_t lms_nrst;
   led_t       leds_n;

   // Reference model state
   lms_word_t  rx_last_i [NUM_CHANNELS];
   iq_pair_t   rx_exp [NUM_CHANNELS];
   logic       rx_pend [NUM_CHANNELS];
   int         rx_pairs [NUM_CHANNELS];
   iq_pair_t   tx_q [NUM_CHANNELS][$];   // Accepted pairs, oldest first
   iq_pair_t   tx_cur [NUM_CHANNELS];
   logic       tx_acc [NUM_CHANNELS];
   logic       tx_phase;                 // Expected iqsel on both DAC buses

   logic [31:0] rng_state;
   logic [31:0] r;
   int          checks;
   int          errors;
   int          tests;
   int          err_start;
   int          cycle_cnt;

   lms_frontend_top dut0 (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .rx_bus_0_i   (rx_bus[0]),
      .rx_bus_1_i   (rx_bus[1]),
      .rx_pair_0_o  (rx_pair[0]),
      .rx_pair_1_o  (rx_pair[1]),
      .rx_valid_0_o (rx_valid[0]),
      .rx_valid_1_o (rx_valid[1]),
      .tx_pair_0_i  (tx_pair[0]),
      .tx_pair_1_i  (tx_pair[1]),
      .tx_valid_0_i (tx_valid[0]),
      .tx_valid_1_i (tx_valid[1]),
      .tx_ready_0_o (tx_ready[0]),
      .tx_ready_1_o (tx_ready[1]),
      .tx_bus_0_o   (tx_bus[0]),
      .tx_bus_1_o   (tx_bus[1]),
      .lms_nrst_o   (lms_nrst),
      .leds_n_o     (leds_n)
   );

   bind lms_frontend_top lms_frontend_properties props0 (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .wb_req_i     (wb_req_i),
      .wb_rsp_o     (wb_rsp_o),
      .tx_bus_0_o   (tx_bus_0_o),
      .tx_bus_1_o   (tx_bus_1_o),
      .tx_ready_0_o (tx_ready_0_o),
      .tx_ready_1_o (tx_ready_1_o)
   );

   initial
   begin
      dsp_clk = 1'b0;
      forever #20 dsp_clk = ~dsp_clk;   // 40 ns period
   end

   // DAC phase model, Q after reset and flipping on every edge
   always @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         tx_phase <= 1'b1;
      end
      else
      begin
         tx_phase <= ~tx_phase;
      end
   end

   // Watchdog
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT)
      begin
         @(posedge dsp_clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   task automatic step();
      @(posedge dsp_clk);
      #2;
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("[FAIL] %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
         errors++;
      end
   endtask

   // One classic cycle, held through the ack cycle
   task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                            output wb_data_t rdat);
      int waited;
      waited = 0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      step();
      while (!wb_rsp.ack && waited < ACK_LIMIT)
      begin
         step();
         waited++;
      end
      assert (wb_rsp.ack)
      else
      begin
         $display("No Wishbone ack came back for address %0d", adr);
         errors++;
      end
      rdat = wb_rsp.dat;
      step();
      wb_req = '0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_data_t wdat);
      wb_data_t unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic read_check(input wb_adr_t adr, input wb_data_t exp, input string what);
      wb_data_t rdat;
      wb_access(1'b0, adr, '0, rdat);
      check_value(what, rdat, exp);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d %s finished with %0d errors", tests, name, errors - err_start);
      err_start = errors;
   endtask

   initial
   begin
      rng_state = 32'd25;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      err_start = 0;
      arst_n_i  = 1'b0;
      wb_req    = '0;
      for (int ch = 0; ch < NUM_CHANNELS; ch++)
      begin
         rx_bus[ch]    = '0;
         tx_pair[ch]   = '0;
         tx_valid[ch]  = 1'b0;
         rx_last_i[ch] = '0;   // Matches the I hold after reset
         rx_pend[ch]   = 1'b0;
         rx_pairs[ch]  = 0;
         tx_acc[ch]    = 1'b0;
         tx_cur[ch]    = '0;
      end
      repeat (RST_CYCLES) @(posedge dsp_clk);
      #2;
      arst_n_i = 1'b1;
      step();

      // Reset state
      check_value("lms_nrst after reset", 32'(lms_nrst), 32'h0);
      check_value("leds_n after reset", 32'(leds_n), 32'h1F);
      check_value("rx_valid 0 after reset", 32'(rx_valid[0]), 32'h0);
      check_value("rx_valid 1 after reset", 32'(rx_valid[1]), 32'h0);
      read_check(REG_ID, FRONTEND_ID, "ID register");
      read_check(REG_CTRL, 32'h0, "CTRL after reset");
      read_check(REG_LEDS, 32'h0, "LEDS after reset");
      read_check(REG_RX_CNT0, 32'h0, "CNT0 after reset");
      read_check(REG_RX_CNT1, 32'h0, "CNT1 after reset");
      end_test("reset state");

      // Register access with random data
      for (int n = 0; n < REG_ITERS; n++)
      begin
         r = next_rand();
         wb_write(REG_CTRL, r);
         check_value("lms_nrst after CTRL write", 32'(lms_nrst), 32'(r[5:4]));
         read_check(REG_CTRL, r & 32'h3F, "CTRL readback");
         r = next_rand();
         wb_write(REG_LEDS, r);
         check_value("leds_n after LEDS write", 32'(leds_n), 32'(r[4:0] ^ 5'h1F));
         read_check(REG_LEDS, r & 32'h1F, "LEDS readback");
      end
      end_test("register access");

      // Receive de-interleaving, both channels on
      wb_write(REG_CTRL, 32'h33);
      for (int n = 0; n <= RX_CYCLES; n++)
      begin
         step();
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            check_value("rx_valid", 32'(rx_valid[ch]), 32'(rx_pend[ch]));
            if (rx_pend[ch])
            begin
               check_value("rx pair", 32'(rx_pair[ch]), 32'(rx_exp[ch]));
            end
            r = next_rand();
            rx_bus[ch].iqsel = (n < RX_CYCLES) ? r[12] : 1'b0;
            rx_bus[ch].data  = (n < RX_CYCLES) ? r[11:0] : '0;
            rx_pend[ch]      = rx_bus[ch].iqsel;
            if (rx_bus[ch].iqsel)
            begin
               rx_exp[ch].i = rx_last_i[ch];   // Repeated Q reuses the last I
               rx_exp[ch].q = rx_bus[ch].data;
               rx_pairs[ch]++;
            end
            else
            begin
               rx_last_i[ch] = rx_bus[ch].data;
            end
         end
      end
      step();
      step();   // Let the last pulse reach the counters
      read_check(REG_RX_CNT0, rx_pairs[0] & 32'hFFFF, "CNT0 pair count");
      read_check(REG_RX_CNT1, rx_pairs[1] & 32'hFFFF, "CNT1 pair count");
      end_test("receive de-interleaving");

      // Receive disabled, then counter clear
      wb_write(REG_CTRL, 32'h30);
      for (int n = 0; n <= RX_DIS_CYCLES; n++)
      begin
         step();
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            check_value("rx_valid while disabled", 32'(rx_valid[ch]), 32'h0);
            r = next_rand();
            rx_bus[ch] = (n < RX_DIS_CYCLES) ? r[12:0] : '0;
         end
      end
      step();
      step();
      read_check(REG_RX_CNT0, rx_pairs[0] & 32'hFFFF, "CNT0 held while disabled");
      read_check(REG_RX_CNT1, rx_pairs[1] & 32'hFFFF, "CNT1 held while disabled");
      wb_write(REG_RX_CNT0, next_rand());
      read_check(REG_RX_CNT0, 32'h0, "CNT0 after clear");
      wb_write(REG_RX_CNT1, next_rand());
      read_check(REG_RX_CNT1, 32'h0, "CNT1 after clear");
      end_test("receive disable and counter clear");

      // Transmit with random gaps, drained at the end
      wb_write(REG_CTRL, 32'h3C);
      for (int n = 0; n < TX_CYCLES + 6; n++)
      begin
         step();
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            check_value("tx iqsel", 32'(tx_bus[ch].iqsel), 32'(tx_phase));
            check_value("tx ready", 32'(tx_ready[ch]), 32'(tx_phase));
            if (tx_phase == PHASE_I)
            begin
               tx_cur[ch] = tx_acc[ch] ? tx_q[ch].pop_front() : '0;   // Idle pair is zero
               check_value("tx I word", 32'(tx_bus[ch].data), 32'(tx_cur[ch].i));
            end
            else
            begin
               check_value("tx Q word", 32'(tx_bus[ch].data), 32'(tx_cur[ch].q));
            end
            if (tx_acc[ch])
            begin
               tx_valid[ch] = 1'b0;
            end
            r = next_rand();
            if (!tx_valid[ch] && n < TX_CYCLES && r[1:0] != 2'b00)
            begin
               tx_valid[ch] = 1'b1;
               tx_pair[ch]  = r[31:8];
            end
            tx_acc[ch] = tx_valid[ch] && tx_ready[ch];   // Taken on the coming edge
            if (tx_acc[ch])
            begin
               tx_q[ch].push_back(tx_pair[ch]);
            end
         end
      end
      for (int ch = 0; ch < NUM_CHANNELS; ch++)
      begin
         check_value("tx queue drained", tx_q[ch].size(), 32'h0);
         tx_valid[ch] = 1'b0;
      end
      wb_write(REG_CTRL, 32'h30);
      for (int n = 0; n < TX_DIS_CYCLES; n++)
      begin
         step();
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            check_value("tx iqsel while disabled", 32'(tx_bus[ch].iqsel), 32'(tx_phase));
            check_value("tx ready while disabled", 32'(tx_ready[ch]), 32'h0);
            check_value("tx word while disabled", 32'(tx_bus[ch].data), 32'h0);
            r = next_rand();
            tx_valid[ch] = r[0];
            tx_pair[ch]  = r[31:8];
         end
      end
      tx_valid[0] = 1'b0;
      tx_valid[1] = 1'b0;
      end_test("transmit interleaving");

      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- lms_frontend_properties.sv
// Bound to lms_frontend_top, every check is held off while arst_n_i is low
module lms_frontend_properties
   import lms_pkg::*;
   import wb_regs_pkg::*;
(
   input logic     dsp_clk,
   input logic     arst_n_i,
   input wb_req_t  wb_req_i,
   input wb_rsp_t  wb_rsp_o,
   input lms_bus_t tx_bus_0_o,
   input lms_bus_t tx_bus_1_o,
   input logic     tx_ready_0_o,
   input logic     tx_ready_1_o
);

   timeunit 1ns;
   timeprecision 100ps;

   logic running_q;   // Set one edge after reset release

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         running_q <= 1'b0;
      end
      else
      begin
         running_q <= 1'b1;
      end
   end

   // Ack only answers a live request
   ack_needs_req: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
      else $error("Wishbone ack without cyc and stb");

   ack_single: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      wb_rsp_o.ack |=> !wb_rsp_o.ack)
      else $error("Wishbone ack high for two cycles");

   // Free-running phase on both DAC buses
   iqsel_toggle_0: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      running_q |-> (tx_bus_0_o.iqsel != $past(tx_bus_0_o.iqsel)))
      else $error("Channel 0 iqsel did not toggle");

   iqsel_toggle_1: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      running_q |-> (tx_bus_1_o.iqsel != $past(tx_bus_1_o.iqsel)))
      else $error("Channel 1 iqsel did not toggle");

   ready_on_q_0: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      tx_ready_0_o |-> tx_bus_0_o.iqsel)
      else $error("Channel 0 ready while an I word is on the bus");

   ready_on_q_1: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      tx_ready_1_o |-> tx_bus_1_o.iqsel)
      else $error("Channel 1 ready while an I word is on the bus");

endmodule

//--- lms_frontend_top.sv
// Two-channel LMS6002D front end on dsp_clk only, converter clocks and pads handled outside
module lms_frontend_top
   import lms_pkg::*;
   import wb_regs_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       arst_n_i,
   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,
   input  lms_bus_t   rx_bus_0_i,
   input  lms_bus_t   rx_bus_1_i,
   output iq_pair_t   rx_pair_0_o,
   output iq_pair_t   rx_pair_1_o,
   output logic       rx_valid_0_o,
   output logic       rx_valid_1_o,
   input  iq_pair_t   tx_pair_0_i,
   input  iq_pair_t   tx_pair_1_i,
   input  logic       tx_valid_0_i,
   input  logic       tx_valid_1_i,
   output logic       tx_ready_0_o,
   output logic       tx_ready_1_o,
   output lms_bus_t   tx_bus_0_o,
   output lms_bus_t   tx_bus_1_o,
   output chan_mask_t lms_nrst_o,
   output led_t       leds_n_o
);

   chan_mask_t rx_en;
   chan_mask_t tx_en;
   chan_mask_t rx_valid;   // Fed back for pair counting

   assign rx_valid     = {rx_valid_1_o, rx_valid_0_o};

   frontend_ctrl_regs regs0 (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .rx_valid_i (rx_valid),
      .rx_en_o    (rx_en),
      .tx_en_o    (tx_en),
      .lms_nrst_o (lms_nrst_o),
      .leds_n_o   (leds_n_o)
   );

   lms_rx_deinterleave rx0 (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .enable_i (rx_en[0]),
      .bus_i    (rx_bus_0_i),
      .pair_o   (rx_pair_0_o),
      .valid_o  (rx_valid_0_o)
   );

   lms_rx_deinterleave rx1 (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .enable_i (rx_en[1]),
      .bus_i    (rx_bus_1_i),
      .pair_o   (rx_pair_1_o),
      .valid_o  (rx_valid_1_o)
   );

   lms_tx_interleave tx0 (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .enable_i (tx_en[0]),
      .pair_i   (tx_pair_0_i),
      .valid_i  (tx_valid_0_i),
      .ready_o  (tx_ready_0_o),
      .bus_o    (tx_bus_0_o)
   );

   lms_tx_interleave tx1 (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .enable_i (tx_en[1]),
      .pair_i   (tx_pair_1_i),
      .valid_i  (tx_valid_1_i),
      .ready_o  (tx_ready_1_o),
      .bus_o    (tx_bus_1_o)
   );

endmodule

//--- frontend_ctrl_regs.sv
// Wishbone classic slave with single-cycle ack, full-word writes only, two 16-bit wrapping counters
module frontend_ctrl_regs
   import lms_pkg::*;
   import wb_regs_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       arst_n_i,
   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,
   input  chan_mask_t rx_valid_i,
   output chan_mask_t rx_en_o,
   output chan_mask_t tx_en_o,
   output chan_mask_t lms_nrst_o,
   output led_t       leds_n_o
);

   logic [CTRL_W-1:0] ctrl_q;
   led_t              leds_q;
   rx_cnt_t           cnt_q [NUM_CHANNELS];
   logic              ack_q;
   wb_data_t          rdat_q;
   wb_data_t          rd_mux;
   logic              req_hit;
   logic              wr_hit;

   // New request only while no ack is out, so ack never lasts two cycles
   assign req_hit = wb_req_i.cyc && wb_req_i.stb && !ack_q;
   assign wr_hit  = req_hit && wb_req_i.we;

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= req_hit;
      end
   end

   // Control and LED registers update on the ack edge
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ctrl_q <= CTRL_RST;
         leds_q <= LEDS_RST;
      end
      else if (wr_hit)
      begin
         if (wb_req_i.adr == REG_CTRL)
         begin
            ctrl_q <= wb_req_i.dat[CTRL_W-1:0];
         end
         if (wb_req_i.adr == REG_LEDS)
         begin
            leds_q <= wb_req_i.dat[LED_W-1:0];
         end
      end
   end

   // Pair counters, a write clears and beats a same-edge pulse
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cnt_q <= '{default: '0};
      end
      else
      begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            if (wr_hit && (wb_req_i.adr == REG_RX_CNT0 + wb_adr_t'(ch)))
            begin
               cnt_q[ch] <= '0;
            end
            else if (rx_valid_i[ch])
            begin
               cnt_q[ch] <= cnt_q[ch] + 1'b1;   // Wraps at 2^16
            end
         end
      end
   end

   always_comb
   begin
      rd_mux = '0;   // Unmapped addresses read zero
      case (wb_req_i.adr)
         REG_CTRL:    rd_mux = wb_data_t'(ctrl_q);
         REG_LEDS:    rd_mux = wb_data_t'(leds_q);
         REG_RX_CNT0: rd_mux = wb_data_t'(cnt_q[0]);
         REG_RX_CNT1: rd_mux = wb_data_t'(cnt_q[1]);
         REG_ID:      rd_mux = FRONTEND_ID;
         default:     rd_mux = '0;
      endcase
   end

   // Read data captured with the request, valid alongside ack
   always_ff @(posedge dsp_clk)
   begin
      if (req_hit)
      begin
         rdat_q <= rd_mux;
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rdat_q;

   assign rx_en_o    = ctrl_q[CTRL_RX_EN_LSB +: NUM_CHANNELS];
   assign tx_en_o    = ctrl_q[CTRL_TX_EN_LSB +: NUM_CHANNELS];
   assign lms_nrst_o = ctrl_q[CTRL_NRST_LSB +: NUM_CHANNELS];
   assign leds_n_o   = ~leds_q;   // Pins sink current to light

endmodule

//--- lms_tx_interleave.sv
// One channel of DAC interleaving, iqsel runs free from reset and at most one pair is in flight
module lms_tx_interleave
   import lms_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     arst_n_i,
   input  logic     enable_i,
   input  iq_pair_t pair_i,
   input  logic     valid_i,
   output logic     ready_o,
   output lms_bus_t bus_o
);

   iq_phase_t phase_q;   // Phase of the word now on the bus
   lms_word_t word_q;
   lms_word_t q_hold;    // Q half waiting for the second cycle
   logic      accept;

   // A new pair can start only while a Q word is on the bus
   assign ready_o = enable_i && (phase_q == PHASE_Q);
   assign accept  = valid_i && ready_o;

   // Phase toggles on every edge, enabled or not
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         phase_q <= PHASE_Q;
      end
      else
      begin
         phase_q <= (phase_q == PHASE_Q) ? PHASE_I : PHASE_Q;
      end
   end

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         word_q <= '0;
      end
      else if (phase_q == PHASE_Q)
      begin
         word_q <= accept ? pair_i.i : '0;   // Idle pair sends zero
      end
      else
      begin
         word_q <= q_hold;   // Second half of the pair started last edge
      end
   end

   // Loaded on every I edge so an idle pair stays all zero
   always_ff @(posedge dsp_clk)
   begin
      if (phase_q == PHASE_Q)
      begin
         q_hold <= accept ? pair_i.q : '0;
      end
   end

   assign bus_o.iqsel = phase_q;
   assign bus_o.data  = word_q;

endmodule

//--- lms_rx_deinterleave.sv
// One channel of ADC de-interleaving, no back-pressure, repeated Q words reuse the last I word
module lms_rx_deinterleave
   import lms_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     arst_n_i,
   input  logic     enable_i,
   input  lms_bus_t bus_i,
   output iq_pair_t pair_o,
   output logic     valid_o
);

   lms_word_t i_hold;     // Last I word seen on the bus
   iq_pair_t  pair_q;
   logic      valid_q;
   logic      sample_q;   // Q word on the bus of an enabled channel

   assign sample_q = enable_i && (bus_i.iqsel == PHASE_Q);

   // Stage one keeps the I word until its Q partner shows up
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         i_hold <= '0;   // First pair before any I word pairs with zero
      end
      else if (enable_i && (bus_i.iqsel == PHASE_I))
      begin
         i_hold <= bus_i.data;
      end
   end

   // Stage two registers the complete pair on the Q edge
   always_ff @(posedge dsp_clk)
   begin
      if (sample_q)
      begin
         pair_q.i <= i_hold;
         pair_q.q <= bus_i.data;
      end
   end

   // One cycle strobe per pair
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= sample_q;
      end
   end

   assign pair_o  = pair_q;
   assign valid_o = valid_q;

endmodule

//--- wb_regs_pkg.sv
// Wishbone classic register map, 32-bit words at word addresses, no byte selects
package wb_regs_pkg;

   localparam int WB_DATA_W = 32;
   localparam int WB_ADR_W  = 3;    // Word address

   typedef logic [WB_DATA_W-1:0] wb_data_t;
   typedef logic [WB_ADR_W-1:0]  wb_adr_t;

   // Host request, held by the master until ack
   typedef struct packed
   {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_adr_t  adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed
   {
      logic     ack;
      wb_data_t dat;   // Valid in the ack cycle
   } wb_rsp_t;

   // Register addresses
   localparam wb_adr_t REG_CTRL    = wb_adr_t'(0);
   localparam wb_adr_t REG_LEDS    = wb_adr_t'(1);
   localparam wb_adr_t REG_RX_CNT0 = wb_adr_t'(2);
   localparam wb_adr_t REG_RX_CNT1 = wb_adr_t'(3);
   localparam wb_adr_t REG_ID      = wb_adr_t'(4);   // Read-only

   // REG_CTRL field layout
   localparam int CTRL_RX_EN_LSB = 0;
   localparam int CTRL_TX_EN_LSB = 2;
   localparam int CTRL_NRST_LSB  = 4;
   localparam int CTRL_W         = 6;

   localparam int RX_CNT_W = 16;
   localparam int LED_W    = 5;

   typedef logic [RX_CNT_W-1:0] rx_cnt_t;
   typedef logic [LED_W-1:0]    led_t;   // 1 means lit

   // Reset values hold both transceivers in reset with all LEDs dark
   localparam logic [CTRL_W-1:0] CTRL_RST = '0;
   localparam led_t              LEDS_RST = '0;

   localparam wb_data_t FRONTEND_ID = 32'h4C4D_5332;

endpackage

//--- lms_pkg.sv
// LMS data path types for a single dsp_clk domain with 12-bit converter words and two channels
package lms_pkg;

   // Converter word width of the LMS6002D ADC and DAC buses
   localparam int LMS_WORD_W   = 12;

   // Transceiver channels on the board
   localparam int NUM_CHANNELS = 2;

   // One ADC or DAC word
   typedef logic [LMS_WORD_W-1:0] lms_word_t;

   // One bit per channel, used for enable and reset masks
   typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

   // Word phase on the shared bus, matches the iqsel pin level
   typedef enum logic
   {
      PHASE_I = 1'b0,
      PHASE_Q = 1'b1
   } iq_phase_t;

   // Complete complex sample
   typedef struct packed
   {
      lms_word_t i;
      lms_word_t q;
   } iq_pair_t;

   // Pin bundle of one converter bus, receive or transmit
   typedef struct packed
   {
      logic      iqsel;   // 0 marks I, 1 marks Q
      lms_word_t data;
   } lms_bus_t;

endpackage
